/* logic/mfp_macros.svh */
`ifndef MFP_MACROS_SVH
`define MFP_MACROS_SVH

// address map, haddr[31:28]
`define MFP_RAM_BASE        4'h0
`define MFP_GPIO_BASE       4'h1
`define MFP_UART_BASE       4'h2

// ram depth in words, as address bits
`define MFP_RAM_ADDR_WIDTH  10

// clock cycles per uart bit
`define MFP_UART_DIV        8

// debug reset pulse length in cycles
`define MFP_TRST_CYCLES     16

`endif

/* logic/mfp_pkg.sv */
`default_nettype none

package mfp_pkg;

    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_e;

    // one address phase plus the write data of its data phase
    typedef struct packed {
        logic [31:0] haddr;
        htrans_e     htrans;
        logic        hwrite;
        logic [31:0] hwdata;
    } ahb_req_t;

    typedef struct packed {
        logic [31:0] hrdata;
        logic        hreadyout;
        logic        hresp;
    } ahb_rsp_t;

    typedef enum logic [1:0] {
        SEL_RAM,
        SEL_GPIO,
        SEL_UART,
        SEL_NONE
    } slave_sel_e;

    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

endpackage

`default_nettype wire

/* logic/mfp_baud_timer.sv */
`default_nettype none
`include "mfp_macros.svh"

module mfp_baud_timer (
    input  logic hclk,
    input  logic rst_n,
    input  logic run,
    output logic tick
);

    localparam int CW = $clog2(`MFP_UART_DIV);

    logic [CW-1:0] count;

    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!run || tick) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // last cycle of the bit
    assign tick = run && (count == CW'(`MFP_UART_DIV - 1));

endmodule

`default_nettype wire

/* logic/mfp_ejtag_reset.sv */
`default_nettype none
`include "mfp_macros.svh"

module mfp_ejtag_reset (
    input  logic hclk,
    input  logic rst_n,
    input  logic probe_n,
    output logic trst_n
);

    localparam int CW = $clog2(`MFP_TRST_CYCLES + 1);

    logic [CW-1:0] count;
    logic          done;

    // saturates at the pulse length
    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!done) begin
            count <= count + 1'b1;
        end
    end

    assign done   = (count == CW'(`MFP_TRST_CYCLES));
    assign trst_n = done & probe_n;

    // pulse never comes back until the next reset
    a_done_sticky: assert property (@(posedge hclk) disable iff (!rst_n)
        done |=> (done && trst_n == probe_n));

endmodule

`default_nettype wire

/* logic/mfp_ahb_decoder.sv */
`default_nettype none
`include "mfp_macros.svh"

module mfp_ahb_decoder (
    input  logic              hclk,
    input  logic              rst_n,
    input  mfp_pkg::ahb_req_t req,
    input  mfp_pkg::ahb_rsp_t rsp_ram,
    input  mfp_pkg::ahb_rsp_t rsp_gpio,
    input  mfp_pkg::ahb_rsp_t rsp_uart,
    output logic              hsel_ram,
    output logic              hsel_gpio,
    output logic              hsel_uart,
    output logic              hready,
    output mfp_pkg::ahb_rsp_t rsp
);

    import mfp_pkg::*;

    slave_sel_e addr_sel;
    slave_sel_e dph_sel;
    logic       active;
    logic       err_first;
    logic       err_second;
    ahb_rsp_t   rsp_err;

    assign active = (req.htrans == HTRANS_NONSEQ) || (req.htrans == HTRANS_SEQ);

    always_comb begin
        case (req.haddr[31:28])
            `MFP_RAM_BASE:  addr_sel = SEL_RAM;
            `MFP_GPIO_BASE: addr_sel = SEL_GPIO;
            `MFP_UART_BASE: addr_sel = SEL_UART;
            default:        addr_sel = SEL_NONE;
        endcase
    end

    assign hsel_ram  = (addr_sel == SEL_RAM);
    assign hsel_gpio = (addr_sel == SEL_GPIO);
    assign hsel_uart = (addr_sel == SEL_UART);

    // idle transfers select the default slave in the data phase
    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            dph_sel <= SEL_NONE;
        end else if (hready) begin
            dph_sel <= active ? addr_sel : SEL_NONE;
        end
    end

    // two-cycle error response for unmapped transfers
    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            err_first  <= 1'b0;
            err_second <= 1'b0;
        end else begin
            err_first  <= hready && active && (addr_sel == SEL_NONE);
            err_second <= err_first;
        end
    end

    assign rsp_err = '{hrdata: 32'b0, hreadyout: !err_first, hresp: err_first || err_second};

    always_comb begin
        case (dph_sel)
            SEL_RAM:  rsp = rsp_ram;
            SEL_GPIO: rsp = rsp_gpio;
            SEL_UART: rsp = rsp_uart;
            default:  rsp = rsp_err;
        endcase
    end

    assign hready = rsp.hreadyout;

    // error ends with hready high on the following edge
    a_err_two_cycle: assert property (@(posedge hclk) disable iff (!rst_n)
        err_first |=> (rsp.hresp && hready));

endmodule

`default_nettype wire

/* logic/mfp_ahb_ram.sv */
`default_nettype none
`include "mfp_macros.svh"

module mfp_ahb_ram (
    input  logic              hclk,
    input  logic              rst_n,
    input  logic              hsel,
    input  logic              hready,
    input  mfp_pkg::ahb_req_t req,
    output mfp_pkg::ahb_rsp_t rsp
);

    import mfp_pkg::*;

    localparam int AW = `MFP_RAM_ADDR_WIDTH;

    logic [31:0]   mem [0:(1 << AW) - 1];
    logic [AW-1:0] addr;
    logic [AW-1:0] dph_addr;
    logic          dph_write;
    logic          accept;
    logic [31:0]   rdata;

    assign addr   = req.haddr[AW+1:2];
    assign accept = hready && hsel &&
                    ((req.htrans == HTRANS_NONSEQ) || (req.htrans == HTRANS_SEQ));

    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            dph_write <= 1'b0;
        end else if (hready) begin
            dph_write <= accept && req.hwrite;
        end
    end

    always_ff @(posedge hclk) begin
        if (accept) begin
            dph_addr <= addr;
        end
    end

    // pending write lands at the end of its data phase
    always_ff @(posedge hclk) begin
        if (hready && dph_write) begin
            mem[dph_addr] <= req.hwdata;
        end
    end

    // read straight after a write to the same word takes the write data
    always_ff @(posedge hclk) begin
        if (accept && !req.hwrite) begin
            if (dph_write && dph_addr == addr) begin
                rdata <= req.hwdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

    assign rsp = '{hrdata: rdata, hreadyout: 1'b1, hresp: 1'b0};

endmodule

`default_nettype wire

/* logic/mfp_ahb_gpio.sv */
`default_nettype none

module mfp_ahb_gpio (
    input  logic              hclk,
    input  logic              rst_n,
    input  logic              hsel,
    input  logic              hready,
    input  mfp_pkg::ahb_req_t req,
    input  logic [17:0]       io_switches,
    input  logic [4:0]        io_buttons,
    output mfp_pkg::ahb_rsp_t rsp,
    output logic [17:0]       io_red_leds,
    output logic [8:0]        io_green_leds
);

    import mfp_pkg::*;

    logic        dph_write;
    logic [1:0]  dph_reg;
    logic [31:0] rdata;

    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            dph_write <= 1'b0;
            dph_reg   <= 2'd0;
        end else if (hready) begin
            dph_write <= hsel && req.hwrite &&
                         ((req.htrans == HTRANS_NONSEQ) || (req.htrans == HTRANS_SEQ));
            dph_reg   <= req.haddr[3:2];
        end
    end

    // offsets 8 and 12 are inputs only
    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            io_red_leds   <= 18'b0;
            io_green_leds <= 9'b0;
        end else if (hready && dph_write) begin
            case (dph_reg)
                2'd0:    io_red_leds   <= req.hwdata[17:0];
                2'd1:    io_green_leds <= req.hwdata[8:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        case (dph_reg)
            2'd0:    rdata = {14'b0, io_red_leds};
            2'd1:    rdata = {23'b0, io_green_leds};
            2'd2:    rdata = {14'b0, io_switches};
            default: rdata = {27'b0, io_buttons};
        endcase
    end

    assign rsp = '{hrdata: rdata, hreadyout: 1'b1, hresp: 1'b0};

endmodule

`default_nettype wire

/* logic/mfp_uart_tx.sv */
`default_nettype none

module mfp_uart_tx (
    input  logic              hclk,
    input  logic              rst_n,
    input  logic              hsel,
    input  logic              hready,
    input  mfp_pkg::ahb_req_t req,
    output mfp_pkg::ahb_rsp_t rsp,
    output logic              uart_tx
);

    import mfp_pkg::*;

    uart_state_e state;
    logic        dph_valid;
    logic        dph_write;
    logic        dph_status;
    logic        busy;
    logic        stall;
    logic        load;
    logic        tick;
    logic [2:0]  bit_cnt;
    logic [7:0]  shift;

    assign busy = (state != UART_IDLE);

    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            dph_valid  <= 1'b0;
            dph_write  <= 1'b0;
            dph_status <= 1'b0;
        end else if (hready) begin
            dph_valid  <= hsel &&
                          ((req.htrans == HTRANS_NONSEQ) || (req.htrans == HTRANS_SEQ));
            dph_write  <= req.hwrite;
            dph_status <= req.haddr[2];
        end
    end

    // data write waits here while a frame is on the line
    assign stall = dph_valid && dph_write && !dph_status && busy;
    assign load  = hready && dph_valid && dph_write && !dph_status && !busy;

    assign rsp = '{hrdata: dph_status ? {31'b0, busy} : 32'b0,
                   hreadyout: !stall,
                   hresp: 1'b0};

    mfp_baud_timer baud_timer (
        .hclk   ( hclk  ),
        .rst_n  ( rst_n ),
        .run    ( busy  ),
        .tick   ( tick  )
    );

    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= UART_IDLE;
            bit_cnt <= 3'd0;
            uart_tx <= 1'b1;
        end else begin
            case (state)
                UART_IDLE: begin
                    if (load) begin
                        state   <= UART_START;
                        uart_tx <= 1'b0;
                    end
                end
                UART_START: begin
                    if (tick) begin
                        state   <= UART_DATA;
                        bit_cnt <= 3'd0;
                        uart_tx <= shift[0];
                    end
                end
                UART_DATA: begin
                    if (tick && bit_cnt == 3'd7) begin
                        state   <= UART_STOP;
                        uart_tx <= 1'b1;
                    end else if (tick) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        uart_tx <= shift[0];
                    end
                end
                default: begin
                    if (tick) begin
                        state <= UART_IDLE;
                    end
                end
            endcase
        end
    end

    // lsb first
    always_ff @(posedge hclk) begin
        if (load) begin
            shift <= req.hwdata[7:0];
        end else if (tick && (state == UART_START || state == UART_DATA)) begin
            shift <= {1'b0, shift[7:1]};
        end
    end

    a_idle_line_high: assert property (@(posedge hclk) disable iff (!rst_n)
        (state == UART_IDLE) |-> uart_tx);

endmodule

`default_nettype wire

/* logic/mfp_system.sv */
`default_nettype none

module mfp_system (
    input  logic              hclk,
    input  logic              rst_n,

    input  mfp_pkg::ahb_req_t ahb_req,
    output mfp_pkg::ahb_rsp_t ahb_rsp,

    input  logic              ej_trst_probe_n,
    output logic              ej_trst_n,

    input  logic [17:0]       io_switches,
    input  logic [4:0]        io_buttons,
    output logic [17:0]       io_red_leds,
    output logic [8:0]        io_green_leds,

    output logic              uart_tx
);

    import mfp_pkg::*;

    ahb_rsp_t rsp_ram;
    ahb_rsp_t rsp_gpio;
    ahb_rsp_t rsp_uart;
    logic     hsel_ram;
    logic     hsel_gpio;
    logic     hsel_uart;
    logic     hready;

    // holds the debug port in reset for a while after power-up
    mfp_ejtag_reset ejtag_reset (
        .hclk     ( hclk            ),
        .rst_n    ( rst_n           ),
        .probe_n  ( ej_trst_probe_n ),
        .trst_n   ( ej_trst_n       )
    );

    mfp_ahb_decoder ahb_decoder (
        .hclk       ( hclk      ),
        .rst_n      ( rst_n     ),
        .req        ( ahb_req   ),
        .rsp_ram    ( rsp_ram   ),
        .rsp_gpio   ( rsp_gpio  ),
        .rsp_uart   ( rsp_uart  ),
        .hsel_ram   ( hsel_ram  ),
        .hsel_gpio  ( hsel_gpio ),
        .hsel_uart  ( hsel_uart ),
        .hready     ( hready    ),
        .rsp        ( ahb_rsp   )
    );

    mfp_ahb_ram ahb_ram (
        .hclk    ( hclk     ),
        .rst_n   ( rst_n    ),
        .hsel    ( hsel_ram ),
        .hready  ( hready   ),
        .req     ( ahb_req  ),
        .rsp     ( rsp_ram  )
    );

    mfp_ahb_gpio ahb_gpio (
        .hclk           ( hclk          ),
        .rst_n          ( rst_n         ),
        .hsel           ( hsel_gpio     ),
        .hready         ( hready        ),
        .req            ( ahb_req       ),
        .io_switches    ( io_switches   ),
        .io_buttons     ( io_buttons    ),
        .rsp            ( rsp_gpio      ),
        .io_red_leds    ( io_red_leds   ),
        .io_green_leds  ( io_green_leds )
    );

    mfp_uart_tx uart_tx_slave (
        .hclk     ( hclk      ),
        .rst_n    ( rst_n     ),
        .hsel     ( hsel_uart ),
        .hready   ( hready    ),
        .req      ( ahb_req   ),
        .rsp      ( rsp_uart  ),
        .uart_tx  ( uart_tx   )
    );

endmodule

`default_nettype wire

/* dv/tb_mfp_system.sv */
`default_nettype none
`include "mfp_macros.svh"

module tb_mfp_system;

    timeunit 1ns;
    timeprecision 1ps;

    import mfp_pkg::*;

    localparam int DIV  = `MFP_UART_DIV;
    localparam int TRST = `MFP_TRST_CYCLES;
    localparam logic [31:0] RAM_ADDR  = {`MFP_RAM_BASE, 28'h0};
    localparam logic [31:0] GPIO_ADDR = {`MFP_GPIO_BASE, 28'h0};
    localparam logic [31:0] UART_ADDR = {`MFP_UART_BASE, 28'h0};
    localparam logic [17:0] SWITCHES  = 18'h2_b5c3;
    localparam logic [4:0]  BUTTONS   = 5'h15;

    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic        hresp;
        logic        stalls;
        slave_sel_e  sel;
    } row_t;

    logic        hclk;
    logic        rst_n;
    ahb_req_t    ahb_req;
    ahb_rsp_t    ahb_rsp;
    logic        ej_trst_probe_n;
    logic        ej_trst_n;
    logic [17:0] io_switches;
    logic [4:0]  io_buttons;
    logic [17:0] io_red_leds;
    logic [8:0]  io_green_leds;
    logic        uart_tx;

    row_t        rows[$];
    string       names[$];
    logic [7:0]  exp_bytes[$];
    logic [7:0]  got_bytes[$];
    int          frames_seen = 0;
    int          n_frames;
    logic [31:0] lfsr = 32'hd22e_cd8e;
    logic [17:0] exp_red = '0;
    logic [8:0]  exp_green = '0;
    ahb_rsp_t    idle_rsp = '{hrdata: 32'h0, hreadyout: 1'b1, hresp: 1'b0};

    mfp_system UUT (
        .hclk            ( hclk            ),
        .rst_n           ( rst_n           ),
        .ahb_req         ( ahb_req         ),
        .ahb_rsp         ( ahb_rsp         ),
        .ej_trst_probe_n ( ej_trst_probe_n ),
        .ej_trst_n       ( ej_trst_n       ),
        .io_switches     ( io_switches     ),
        .io_buttons      ( io_buttons      ),
        .io_red_leds     ( io_red_leds     ),
        .io_green_leds   ( io_green_leds   ),
        .uart_tx         ( uart_tx         )
    );

    initial begin
        hclk = 1'b0;
        forever #10 hclk = ~hclk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_rsp(input string name, input ahb_rsp_t exp, input ahb_rsp_t act,
                             input logic with_data);
        if (act.hresp !== exp.hresp || act.hreadyout !== exp.hreadyout ||
            (with_data && act.hrdata !== exp.hrdata)) begin
            fail_run($sformatf("[ERROR] %s: expected data %h resp %b, actual data %h resp %b",
                               name, exp.hrdata, exp.hresp, act.hrdata, act.hresp));
        end
    endtask

    task automatic check_leds(input string name, input logic [17:0] exp_r,
                              input logic [8:0] exp_g, input logic [17:0] act_r,
                              input logic [8:0] act_g);
        if (act_r !== exp_r || act_g !== exp_g) begin
            fail_run($sformatf("[ERROR] %s: expected red %h green %h, actual red %h green %h",
                               name, exp_r, exp_g, act_r, act_g));
        end
    endtask

    task automatic check_uart_byte(input string name, input logic [7:0] exp,
                                   input logic [7:0] act);
        if (act !== exp) begin
            fail_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_line(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end else begin
            return s >> 1;
        end
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = '0;
        for (int b = 0; b < 32; b++) begin
            w    = {w[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return w;
    endfunction

    task automatic add_row(input logic write, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [31:0] rdata,
                           input logic hresp, input logic stalls, input string name);
        row_t r;
        r = '{write: write, addr: addr, wdata: wdata, rdata: rdata,
              hresp: hresp, stalls: stalls, sel: SEL_NONE};
        case (addr[31:28])
            `MFP_RAM_BASE:  r.sel = SEL_RAM;
            `MFP_GPIO_BASE: r.sel = SEL_GPIO;
            `MFP_UART_BASE: r.sel = SEL_UART;
            default:        r.sel = SEL_NONE;
        endcase
        if (r.sel == SEL_UART && write && addr[3:2] == 2'd0) begin
            exp_bytes.push_back(wdata[7:0]);
        end
        rows.push_back(r);
        names.push_back($sformatf("%s [%s]", name, r.sel.name()));
    endtask

    task automatic build_table();
        logic [31:0] d [0:3];
        logic [31:0] red;
        logic [31:0] green;
        for (int j = 0; j < 4; j++) begin
            d[j] = rand_word();
        end
        red   = rand_word();
        green = rand_word();
        add_row(1'b1, RAM_ADDR + 32'h000, d[0], 32'h0, 1'b0, 1'b0, "ram write word 0");
        add_row(1'b1, RAM_ADDR + 32'hffc, d[1], 32'h0, 1'b0, 1'b0, "ram write last word");
        add_row(1'b1, RAM_ADDR + 32'h544, d[2], 32'h0, 1'b0, 1'b0, "ram write word 0x151");
        add_row(1'b0, RAM_ADDR + 32'h000, 32'h0, d[0], 1'b0, 1'b0, "ram read word 0");
        add_row(1'b0, RAM_ADDR + 32'hffc, 32'h0, d[1], 1'b0, 1'b0, "ram read last word");
        add_row(1'b1, RAM_ADDR + 32'h200, d[3], 32'h0, 1'b0, 1'b0, "ram write word 0x80");
        add_row(1'b0, RAM_ADDR + 32'h200, 32'h0, d[3], 1'b0, 1'b0, "ram read after write");
        add_row(1'b0, RAM_ADDR + 32'h544, 32'h0, d[2], 1'b0, 1'b0, "ram read word 0x151");
        add_row(1'b1, GPIO_ADDR + 32'h0, red, 32'h0, 1'b0, 1'b0, "red led write");
        add_row(1'b0, GPIO_ADDR + 32'h0, 32'h0, {14'b0, red[17:0]}, 1'b0, 1'b0, "red led read");
        add_row(1'b1, GPIO_ADDR + 32'h4, green, 32'h0, 1'b0, 1'b0, "green led write");
        add_row(1'b0, GPIO_ADDR + 32'h4, 32'h0, {23'b0, green[8:0]}, 1'b0, 1'b0,
                "green led read");
        add_row(1'b1, GPIO_ADDR + 32'h8, 32'hffff_ffff, 32'h0, 1'b0, 1'b0, "switch write");
        add_row(1'b0, GPIO_ADDR + 32'h8, 32'h0, {14'b0, SWITCHES}, 1'b0, 1'b0, "switch read");
        add_row(1'b1, GPIO_ADDR + 32'hc, 32'hffff_ffff, 32'h0, 1'b0, 1'b0, "button write");
        add_row(1'b0, GPIO_ADDR + 32'hc, 32'h0, {27'b0, BUTTONS}, 1'b0, 1'b0, "button read");
        add_row(1'b0, GPIO_ADDR + 32'h0, 32'h0, {14'b0, red[17:0]}, 1'b0, 1'b0,
                "red led read again");
        // nibble 5 is unmapped
        add_row(1'b0, 32'h5000_0010, 32'h0, 32'h0, 1'b1, 1'b1, "unmapped read");
        add_row(1'b0, RAM_ADDR + 32'h000, 32'h0, d[0], 1'b0, 1'b0, "ram read after error");
        add_row(1'b1, UART_ADDR + 32'h0, 32'hffff_ff5a, 32'h0, 1'b0, 1'b0, "uart first byte");
        add_row(1'b0, UART_ADDR + 32'h4, 32'h0, 32'h1, 1'b0, 1'b0, "uart status busy");
        add_row(1'b1, UART_ADDR + 32'h0, 32'h0000_00c3, 32'h0, 1'b0, 1'b1, "uart second byte");
        add_row(1'b0, UART_ADDR + 32'h4, 32'h0, 32'h1, 1'b0, 1'b0, "uart status busy again");
        add_row(1'b0, RAM_ADDR + 32'hffc, 32'h0, d[1], 1'b0, 1'b0, "ram read at the end");
    endtask

    // pipelined master with each data phase overlapping the next address phase
    task automatic run_table();
        row_t     pend;
        string    pend_name;
        logic     pend_valid;
        int       waits;
        ahb_rsp_t exp;
        pend       = '0;
        pend_valid = 1'b0;
        for (int i = 0; i <= rows.size(); i++) begin
            @(negedge hclk);
            check_leds("led pins", exp_red, exp_green, io_red_leds, io_green_leds);
            ahb_req.hwdata = pend.wdata;
            if (i < rows.size()) begin
                ahb_req.haddr  = rows[i].addr;
                ahb_req.htrans = HTRANS_NONSEQ;
                ahb_req.hwrite = rows[i].write;
            end else begin
                ahb_req.htrans = HTRANS_IDLE;
                ahb_req.hwrite = 1'b0;
            end
            waits = 0;
            while (!ahb_rsp.hreadyout) begin
                if (pend_valid && pend.hresp) begin
                    check_line({pend_name, " first error cycle"}, 1'b1, ahb_rsp.hresp);
                end
                waits++;
                @(negedge hclk);
            end
            if (pend_valid) begin
                exp = '{hrdata: pend.rdata, hreadyout: 1'b1, hresp: pend.hresp};
                check_rsp(pend_name, exp, ahb_rsp, !pend.write);
                if ((waits > 0) != pend.stalls) begin
                    fail_run($sformatf("%s: got %0d wait states, which is not what was expected",
                                       pend_name, waits));
                end
                if (pend.stalls && pend.sel == SEL_UART && frames_seen == 0) begin
                    fail_run("uart write was released before the first frame had ended");
                end
                if (pend.write && pend.sel == SEL_GPIO) begin
                    case (pend.addr[3:2])
                        2'd0:    exp_red   = pend.wdata[17:0];
                        2'd1:    exp_green = pend.wdata[8:0];
                        default: ;
                    endcase
                end
            end
            if (i < rows.size()) begin
                pend       = rows[i];
                pend_name  = names[i];
                pend_valid = 1'b1;
            end
        end
    endtask

    task automatic watchdog(input int cycles);
        repeat (cycles) @(posedge hclk);
        fail_run($sformatf("timeout: the run did not finish within %0d clock cycles", cycles));
    endtask

    // samples each bit a little before its middle
    initial begin : uart_monitor
        logic [7:0] data;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge uart_tx);
            repeat (DIV / 2) @(negedge hclk);
            if (uart_tx !== 1'b0) begin
                fail_run("uart monitor: the start bit did not stay low");
            end
            for (int b = 0; b < 8; b++) begin
                repeat (DIV) @(negedge hclk);
                data[b] = uart_tx;
            end
            repeat (DIV) @(negedge hclk);
            if (uart_tx !== 1'b1) begin
                fail_run("uart monitor: the stop bit was not high");
            end
            got_bytes.push_back(data);
            frames_seen++;
        end
    end

    initial begin
        rst_n           = 1'b0;
        ahb_req         = '{haddr: 32'h0, htrans: HTRANS_IDLE, hwrite: 1'b0, hwdata: 32'h0};
        ej_trst_probe_n = 1'b1;
        io_switches     = SWITCHES;
        io_buttons      = BUTTONS;
        build_table();
        n_frames = exp_bytes.size();
        fork
            watchdog(rows.size() * 4 + n_frames * 10 * DIV + 100);
        join_none

        repeat (2) @(negedge hclk);
        check_rsp("bus response in reset", idle_rsp, ahb_rsp, 1'b0);
        check_leds("leds in reset", 18'h0, 9'h0, io_red_leds, io_green_leds);
        check_line("uart line in reset", 1'b1, uart_tx);
        check_line("debug reset in reset", 1'b0, ej_trst_n);
        repeat (2) @(negedge hclk);
        rst_n = 1'b1;

        for (int k = 1; k <= TRST; k++) begin
            @(negedge hclk);
            check_line($sformatf("debug reset after %0d edges", k), k >= TRST, ej_trst_n);
        end
        ej_trst_probe_n = 1'b0;
        @(negedge hclk);
        check_line("debug reset follows probe low", 1'b0, ej_trst_n);
        ej_trst_probe_n = 1'b1;
        @(negedge hclk);
        check_line("debug reset follows probe high", 1'b1, ej_trst_n);

        run_table();
        @(negedge hclk);
        check_leds("led pins at the end", exp_red, exp_green, io_red_leds, io_green_leds);

        wait (frames_seen == n_frames);
        for (int f = 0; f < n_frames; f++) begin
            check_uart_byte($sformatf("uart frame %0d", f), exp_bytes[f], got_bytes[f]);
        end
        // no further start bit once the last frame is out
        for (int c = 0; c < 2 * DIV; c++) begin
            @(negedge hclk);
            check_line("uart line idle after the last frame", 1'b1, uart_tx);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+logic
logic/mfp_pkg.sv
logic/mfp_baud_timer.sv
logic/mfp_ejtag_reset.sv
logic/mfp_ahb_decoder.sv
logic/mfp_ahb_ram.sv
logic/mfp_ahb_gpio.sv
logic/mfp_uart_tx.sv
logic/mfp_system.sv
dv/tb_mfp_system.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_mfp_system -f files.f -o tb_mfp_system \
    && ./obj_dir/tb_mfp_system > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Simulation passed" sim.log 2>/dev/null \
    && echo "run.sh: pass" \
    || { echo "run.sh: fail"; exit 1; }
